//--- logic/exu_pkg.sv
package exu_pkg;

    // Width of data words, operands and program counters
    localparam int XLEN = 32;

    // Shifts only look at this many low bits of the second operand
    localparam int SHAMT_W = 5;

    // Every supported instruction is four bytes long
    localparam logic [XLEN-1:0] INSTR_BYTES = XLEN'(4);

    // Bit positions of the RV32I instruction fields
    // The opcode sits in the bits below RD_LSB
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    // The only funct7 bit that matters here, it picks SUB and SRA
    localparam int FUNCT7_BIT = 30;

    // Major opcodes that the unit executes
    // Any other value is reported as illegal by the decoder
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations
    // The compare group returns its answer in bit 0 of the result
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SRL  = 4'd5,
        SLL  = 4'd6,
        SRA  = 4'd7,
        // Passes the second operand through, used by LUI
        BUF  = 4'd8,
        SLT  = 4'd9,
        SLTU = 4'd10,
        EQ   = 4'd11,
        GE   = 4'd12,
        GEU  = 4'd13
    } alu_op_e;

endpackage

//--- logic/exu_ctrl_if.sv
interface exu_ctrl_if;

    // Instruction is present this cycle
    logic                     valid;

    // Operation and operands for the ALU
    exu_pkg::alu_op_e         alu_op;
    logic [exu_pkg::XLEN-1:0] op1;
    logic [exu_pkg::XLEN-1:0] op2;

    // Sign-extended immediate of whatever format the opcode uses
    logic [exu_pkg::XLEN-1:0] imm;
    logic [exu_pkg::XLEN-1:0] pc;
    logic [4:0]               rd;

    // Control flow flags
    // branch_invert flips the compare bit before the taken decision
    logic                     is_branch;
    logic                     branch_invert;
    logic                     is_jal;
    logic                     is_jalr;
    logic                     illegal;

    // The decoder produces every signal
    modport dec (
        output valid, alu_op, op1, op2, imm, pc, rd,
        output is_branch, branch_invert, is_jal, is_jalr, illegal
    );

    // The ALU only needs the operation and its operands
    modport alu (
        input alu_op, op1, op2
    );

    // Writeback takes the rest
    modport wb (
        input valid, imm, pc, rd,
        input is_branch, branch_invert, is_jal, is_jalr, illegal
    );

endinterface

//--- logic/alu.sv
module alu (
    // First operand is rs1 or the pc
    input  logic [exu_pkg::XLEN-1:0] i_op1,
    // Second operand is rs2 or the immediate
    input  logic [exu_pkg::XLEN-1:0] i_op2,
    input  exu_pkg::alu_op_e         i_alu_ctrl,
    output logic [exu_pkg::XLEN-1:0] o_result
);

    logic [exu_pkg::SHAMT_W-1:0] shamt;
    logic                        cmp;

    // RISC-V ignores the upper bits of the shift amount
    assign shamt = i_op2[exu_pkg::SHAMT_W-1:0];

    // The compare group shares one zero-extended output path
    // Every code outside the group leaves the compare bit low
    always_comb
    begin
        case (i_alu_ctrl)
            exu_pkg::SLT:  cmp = $signed(i_op1) < $signed(i_op2);
            // Plain unsigned compare, as the ISA requires for SLTU
            exu_pkg::SLTU: cmp = i_op1 < i_op2;
            exu_pkg::EQ:   cmp = i_op1 == i_op2;
            exu_pkg::GE:   cmp = $signed(i_op1) >= $signed(i_op2);
            exu_pkg::GEU:  cmp = i_op1 >= i_op2;
            default:       cmp = 1'b0;
        endcase
    end

    always_comb
    begin
        case (i_alu_ctrl)
            // Add and subtract need no sign handling in two's complement
            exu_pkg::ADD:  o_result = i_op1 + i_op2;
            exu_pkg::SUB:  o_result = i_op1 - i_op2;
            exu_pkg::AND:  o_result = i_op1 & i_op2;
            exu_pkg::OR:   o_result = i_op1 | i_op2;
            exu_pkg::XOR:  o_result = i_op1 ^ i_op2;
            exu_pkg::SRL:  o_result = i_op1 >> shamt;
            exu_pkg::SLL:  o_result = i_op1 << shamt;
            // Arithmetic shift copies the sign bit in from the top
            exu_pkg::SRA:  o_result = $unsigned($signed(i_op1) >>> shamt);
            exu_pkg::BUF:  o_result = i_op2;
            // Compare results land in bit 0 and unknown codes give zero
            default:       o_result = {{(exu_pkg::XLEN-1){1'b0}}, cmp};
        endcase
    end

endmodule

//--- logic/exu_decoder.sv
module exu_decoder (
    input  logic                     i_valid,
    input  logic [exu_pkg::XLEN-1:0] i_instr,
    input  logic [exu_pkg::XLEN-1:0] i_pc,
    input  logic [exu_pkg::XLEN-1:0] i_rs1_data,
    input  logic [exu_pkg::XLEN-1:0] i_rs2_data,
    exu_ctrl_if.dec                  o_ctrl
);

    exu_pkg::opcode_e         opcode;
    logic [2:0]               funct3;
    logic                     funct7_bit;
    logic [exu_pkg::XLEN-1:0] imm_i;
    logic [exu_pkg::XLEN-1:0] imm_u;
    logic [exu_pkg::XLEN-1:0] imm_b;
    logic [exu_pkg::XLEN-1:0] imm_j;
    exu_pkg::alu_op_e         arith_op;
    exu_pkg::alu_op_e         branch_op;
    logic                     branch_inv;
    logic                     branch_ok;
    exu_pkg::alu_op_e         alu_op;
    logic [exu_pkg::XLEN-1:0] imm;
    logic                     op1_is_pc;
    logic                     op2_is_rs2;
    logic                     is_branch;
    logic                     is_jal;
    logic                     is_jalr;
    logic                     illegal;

    // Values outside the enum fall into the default arm below
    assign opcode     = exu_pkg::opcode_e'(i_instr[exu_pkg::RD_LSB-1:0]);
    assign funct3     = i_instr[exu_pkg::FUNCT3_LSB +: 3];
    assign funct7_bit = i_instr[exu_pkg::FUNCT7_BIT];

    // I format, the top twelve bits start where rs2 would be
    assign imm_i = {{(exu_pkg::XLEN-12){i_instr[exu_pkg::XLEN-1]}},
                    i_instr[exu_pkg::XLEN-1:exu_pkg::RS2_LSB]};
    // U format keeps the upper twenty bits in place
    assign imm_u = {i_instr[exu_pkg::XLEN-1:exu_pkg::FUNCT3_LSB], 12'b0};
    // B format is scrambled and always even
    assign imm_b = {{(exu_pkg::XLEN-12){i_instr[exu_pkg::XLEN-1]}},
                    i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    // J format takes bits 19:12 straight from the rs1 and funct3 fields
    assign imm_j = {{(exu_pkg::XLEN-20){i_instr[exu_pkg::XLEN-1]}},
                    i_instr[exu_pkg::RS1_LSB+4:exu_pkg::FUNCT3_LSB],
                    i_instr[exu_pkg::RS2_LSB], i_instr[30:21], 1'b0};

    // Shared funct3 map for OP and OP-IMM
    always_comb
    begin
        case (funct3)
            // There is no SUBI, so the funct7 bit is an immediate bit for OP-IMM
            3'b000:  arith_op = (opcode == exu_pkg::OP && funct7_bit) ? exu_pkg::SUB
                                                                      : exu_pkg::ADD;
            3'b001:  arith_op = exu_pkg::SLL;
            3'b010:  arith_op = exu_pkg::SLT;
            3'b011:  arith_op = exu_pkg::SLTU;
            3'b100:  arith_op = exu_pkg::XOR;
            // SRAI carries the same bit in its immediate, so both groups use it
            3'b101:  arith_op = funct7_bit ? exu_pkg::SRA : exu_pkg::SRL;
            3'b110:  arith_op = exu_pkg::OR;
            default: arith_op = exu_pkg::AND;
        endcase
    end

    // Each branch is one ALU compare, possibly inverted in writeback
    always_comb
    begin
        branch_op  = exu_pkg::EQ;
        branch_inv = 1'b0;
        branch_ok  = 1'b1;
        case (funct3)
            3'b000:  branch_op = exu_pkg::EQ;
            3'b001:
            begin
                branch_op  = exu_pkg::EQ;
                branch_inv = 1'b1;
            end
            // BLT is the complement of a signed greater-or-equal
            3'b100:
            begin
                branch_op  = exu_pkg::GE;
                branch_inv = 1'b1;
            end
            // BGE is the complement of a signed less-than
            3'b101:
            begin
                branch_op  = exu_pkg::SLT;
                branch_inv = 1'b1;
            end
            3'b110:
            begin
                branch_op  = exu_pkg::GEU;
                branch_inv = 1'b1;
            end
            3'b111:  branch_op = exu_pkg::GEU;
            // Encodings 010 and 011 are not branches
            default: branch_ok = 1'b0;
        endcase
    end

    // Main decode, defaults describe an I-type add on rs1
    always_comb
    begin
        alu_op     = exu_pkg::ADD;
        imm        = imm_i;
        op1_is_pc  = 1'b0;
        op2_is_rs2 = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        is_jalr    = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            exu_pkg::OP:
            begin
                alu_op     = arith_op;
                op2_is_rs2 = 1'b1;
            end
            exu_pkg::OP_IMM: alu_op = arith_op;
            exu_pkg::LUI:
            begin
                alu_op = exu_pkg::BUF;
                imm    = imm_u;
            end
            exu_pkg::AUIPC:
            begin
                imm       = imm_u;
                op1_is_pc = 1'b1;
            end
            // The ALU sum gives the jump target
            exu_pkg::JAL:
            begin
                imm       = imm_j;
                op1_is_pc = 1'b1;
                is_jal    = 1'b1;
            end
            exu_pkg::JALR:   is_jalr = 1'b1;
            exu_pkg::BRANCH:
            begin
                alu_op     = branch_op;
                imm        = imm_b;
                op2_is_rs2 = 1'b1;
                is_branch  = branch_ok;
                illegal    = !branch_ok;
            end
            // Loads, stores, fences and system instructions end up here
            default:         illegal = 1'b1;
        endcase
    end

    assign o_ctrl.valid         = i_valid;
    assign o_ctrl.alu_op        = alu_op;
    assign o_ctrl.op1           = op1_is_pc ? i_pc : i_rs1_data;
    assign o_ctrl.op2           = op2_is_rs2 ? i_rs2_data : imm;
    assign o_ctrl.imm           = imm;
    assign o_ctrl.pc            = i_pc;
    assign o_ctrl.rd            = i_instr[exu_pkg::RD_LSB +: 5];
    assign o_ctrl.is_branch     = is_branch;
    assign o_ctrl.branch_invert = is_branch & branch_inv;
    assign o_ctrl.is_jal        = is_jal;
    assign o_ctrl.is_jalr       = is_jalr;
    assign o_ctrl.illegal       = illegal;

endmodule

//--- logic/exu_writeback.sv
module exu_writeback (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    exu_ctrl_if.wb                   i_ctrl,
    input  logic [exu_pkg::XLEN-1:0] i_alu_result,
    output logic                     o_valid,
    output logic [4:0]               o_rd,
    output logic                     o_wr_en,
    output logic [exu_pkg::XLEN-1:0] o_result,
    output logic [exu_pkg::XLEN-1:0] o_next_pc,
    output logic                     o_branch_taken,
    output logic                     o_illegal
);

    logic                     branch_taken;
    logic                     is_jump;
    logic                     wr_en;
    logic [exu_pkg::XLEN-1:0] pc_plus4;
    logic [exu_pkg::XLEN-1:0] branch_target;
    logic [exu_pkg::XLEN-1:0] next_pc;
    logic [exu_pkg::XLEN-1:0] wb_result;

    // The ALU compare bit says whether the condition held
    // The invert flag turns it into its complement for BNE, BLT, BLTU and BGE
    assign branch_taken = i_ctrl.is_branch & (i_alu_result[0] ^ i_ctrl.branch_invert);

    assign is_jump       = i_ctrl.is_jal | i_ctrl.is_jalr;
    assign pc_plus4      = i_ctrl.pc + exu_pkg::INSTR_BYTES;
    // The ALU is busy with the compare, so the branch target has its own adder
    assign branch_target = i_ctrl.pc + i_ctrl.imm;

    // Jumps take their target from the ALU sum
    always_comb
    begin
        if (i_ctrl.is_jalr)
        begin
            // JALR always lands on an even address
            next_pc = {i_alu_result[exu_pkg::XLEN-1:1], 1'b0};
        end
        else if (i_ctrl.is_jal)
        begin
            next_pc = i_alu_result;
        end
        else if (branch_taken)
        begin
            next_pc = branch_target;
        end
        else
        begin
            next_pc = pc_plus4;
        end
    end

    // Jumps write the return address into rd
    assign wb_result = is_jump ? pc_plus4 : i_alu_result;

    // Branches have no rd, and illegal instructions must not touch the register file
    assign wr_en = !(i_ctrl.is_branch || i_ctrl.illegal);

    // Control flags of the output record
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_valid        <= 1'b0;
            o_wr_en        <= 1'b0;
            o_branch_taken <= 1'b0;
            o_illegal      <= 1'b0;
        end
        else
        begin
            // o_valid tracks the strobe, the flags hold while it is low
            o_valid <= i_ctrl.valid;
            if (i_ctrl.valid)
            begin
                o_wr_en        <= wr_en;
                o_branch_taken <= branch_taken;
                o_illegal      <= i_ctrl.illegal;
            end
        end
    end

    // Payload of the output record
    always_ff @(posedge i_clk)
    begin
        if (i_ctrl.valid)
        begin
            o_rd      <= i_ctrl.rd;
            o_result  <= wb_result;
            o_next_pc <= next_pc;
        end
    end

endmodule

//--- logic/exu_top.sv
module exu_top (
    input  logic                     i_clk,
    input  logic                     i_arst_n,

    // Instruction input, one per cycle when i_valid is high
    input  logic                     i_valid,
    input  logic [exu_pkg::XLEN-1:0] i_instr,
    input  logic [exu_pkg::XLEN-1:0] i_pc,
    input  logic [exu_pkg::XLEN-1:0] i_rs1_data,
    input  logic [exu_pkg::XLEN-1:0] i_rs2_data,

    // Writeback record, valid one cycle after the instruction
    // There is no back-pressure, so the consumer takes it in that cycle
    output logic                     o_valid,
    output logic [4:0]               o_rd,
    output logic                     o_wr_en,
    output logic [exu_pkg::XLEN-1:0] o_result,
    output logic [exu_pkg::XLEN-1:0] o_next_pc,
    output logic                     o_branch_taken,
    output logic                     o_illegal
);

    // Decoded control and operands, all produced in the same cycle
    exu_ctrl_if ctrl ();

    logic [exu_pkg::XLEN-1:0] alu_result;

    // Opcode decode, immediate build and operand muxing
    exu_decoder u_decoder (
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_ctrl     (ctrl.dec)
    );

    // Arithmetic, logic, shifts and compares
    alu u_alu (
        .i_op1      (ctrl.op1),
        .i_op2      (ctrl.op2),
        .i_alu_ctrl (ctrl.alu_op),
        .o_result   (alu_result)
    );

    // Branch resolution, next pc and the output register
    exu_writeback u_writeback (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_ctrl         (ctrl.wb),
        .i_alu_result   (alu_result),
        .o_valid        (o_valid),
        .o_rd           (o_rd),
        .o_wr_en        (o_wr_en),
        .o_result       (o_result),
        .o_next_pc      (o_next_pc),
        .o_branch_taken (o_branch_taken),
        .o_illegal      (o_illegal)
    );

endmodule

//--- dv/exu_clk_gen.sv
module exu_clk_gen (
    output logic o_clk,
    output logic o_arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free running clock with an 8 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;
    end

    // Reset is low from time zero and released on the fourth rising edge
    initial
    begin
        o_arst_n = 1'b0;
        repeat (4) @(posedge o_clk);
        o_arst_n <= 1'b1;
    end

endmodule

//--- dv/exu_tb.sv
module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [exu_pkg::XLEN-1:0] word_t;

    // Expected output record
    // chk_result is low where the result bus carries nothing defined
    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        logic       wr_en;
        word_t      result;
        word_t      next_pc;
        logic       taken;
        logic       illegal;
        logic       chk_result;
    } rec_t;

    logic        clk;
    logic        arst_n;
    logic        valid;
    word_t       instr;
    word_t       pc;
    word_t       rs1_data;
    word_t       rs2_data;
    logic        out_valid;
    logic [4:0]  out_rd;
    logic        out_wr_en;
    word_t       out_result;
    word_t       out_next_pc;
    logic        out_taken;
    logic        out_illegal;
    logic [31:0] lfsr_state = 32'h6702_2632;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    int          cycle_count = 0;

    exu_clk_gen clk_gen (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    exu_top uut (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_valid        (valid),
        .i_instr        (instr),
        .i_pc           (pc),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .o_valid        (out_valid),
        .o_rd           (out_rd),
        .o_wr_en        (out_wr_en),
        .o_result       (out_result),
        .o_next_pc      (out_next_pc),
        .o_branch_taken (out_taken),
        .o_illegal      (out_illegal)
    );

    // Right-shifting Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Takes n bits with one LFSR step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[exu_pkg::XLEN-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Reference model of the RV32I rules that takes the immediate already decoded
    function automatic rec_t model(input logic [6:0] op, input logic [2:0] f3, input logic alt,
                                   input word_t imm, input word_t p, input word_t a,
                                   input word_t b, input logic [4:0] rd);
        rec_t                             r;
        word_t                            src2;
        logic signed [exu_pkg::XLEN-1:0]  sra;
        r            = '0;
        r.valid      = 1'b1;
        r.rd         = rd;
        r.wr_en      = 1'b1;
        r.chk_result = 1'b1;
        r.next_pc    = p + 4;
        case (op)
            exu_pkg::OP, exu_pkg::OP_IMM:
            begin
                src2 = (op == exu_pkg::OP) ? b : imm;
                sra  = $signed(a) >>> src2[4:0];
                case (f3)
                    // SUB exists only in the register form
                    3'd0:    r.result = (op == exu_pkg::OP && alt) ? a - src2 : a + src2;
                    3'd1:    r.result = a << src2[4:0];
                    3'd2:    r.result = word_t'($signed(a) < $signed(src2));
                    3'd3:    r.result = word_t'(a < src2);
                    3'd4:    r.result = a ^ src2;
                    3'd5:    r.result = alt ? word_t'(sra) : a >> src2[4:0];
                    3'd6:    r.result = a | src2;
                    default: r.result = a & src2;
                endcase
            end
            exu_pkg::LUI:    r.result = imm;
            exu_pkg::AUIPC:  r.result = p + imm;
            exu_pkg::JAL:
            begin
                r.result  = p + 4;
                r.next_pc = p + imm;
            end
            // Target is rs1 plus the immediate with bit 0 dropped
            exu_pkg::JALR:
            begin
                r.result  = p + 4;
                r.next_pc = (a + imm) & ~word_t'(1);
            end
            exu_pkg::BRANCH:
            begin
                case (f3)
                    3'd0:    r.taken = a == b;
                    3'd1:    r.taken = a != b;
                    3'd4:    r.taken = $signed(a) < $signed(b);
                    3'd5:    r.taken = $signed(a) >= $signed(b);
                    3'd6:    r.taken = a < b;
                    default: r.taken = a >= b;
                endcase
                r.wr_en      = 1'b0;
                r.chk_result = 1'b0;
                r.next_pc    = r.taken ? p + imm : p + 4;
            end
            // Anything else is illegal and writes nothing
            default:
            begin
                r.illegal    = 1'b1;
                r.wr_en      = 1'b0;
                r.chk_result = 1'b0;
            end
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // A bubble only needs o_valid low while the payload holds its old value
    task automatic check_record(input rec_t e);
        check_bit("o_valid", out_valid, e.valid);
        if (e.valid)
        begin
            if (e.wr_en)
                check_rd("o_rd", out_rd, e.rd);
            if (e.chk_result)
                check_word("o_result", out_result, e.result);
            check_bit("o_wr_en", out_wr_en, e.wr_en);
            check_word("o_next_pc", out_next_pc, e.next_pc);
            check_bit("o_branch_taken", out_taken, e.taken);
            check_bit("o_illegal", out_illegal, e.illegal);
        end
    endtask

    task automatic drive(input logic v, input word_t ins, input word_t p, input word_t a,
                         input word_t b);
        @(posedge clk);
        valid    <= v;
        instr    <= ins;
        pc       <= p;
        rs1_data <= a;
        rs2_data <= b;
    endtask

    // Runs one instruction and checks its record in the low phase after the capturing edge
    task automatic execute(input word_t ins, input word_t p, input word_t a, input word_t b,
                           input rec_t e);
        drive(1'b1, ins, p, a, b);
        drive(1'b0, ins, p, a, b);
        @(negedge clk);
        check_record(e);
    endtask

    task automatic report_test(input string name, input int start);
        test_count++;
        if (error_count != start)
            failed_tests++;
        $display("test %-10s %s, %0d errors", name,
                 (error_count == start) ? "passed" : "failed", error_count - start);
    endtask

    task automatic test_reset();
        int start;
        start = error_count;
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_bit("o_valid", out_valid, 1'b0);
        check_bit("o_wr_en", out_wr_en, 1'b0);
        check_bit("o_branch_taken", out_taken, 1'b0);
        check_bit("o_illegal", out_illegal, 1'b0);
        report_test("reset", start);
    endtask

    // ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    task automatic test_reg_reg();
        logic [2:0] f3_list [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        logic       alt_list [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        int         start;
        word_t      a;
        word_t      b;
        word_t      p;
        word_t      ins;
        logic [4:0] rd;
        start = error_count;
        for (int i = 0; i < 10; i++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                a  = rand_bits(32);
                b  = rand_bits(32);
                p  = rand_bits(30) << 2;
                rd = 5'(rand_bits(5));
                // Rounds walk the sign combinations and round 2 adds a shift amount above 31
                a[31] = (k == 0) || (k == 3);
                b[31] = (k == 1) || (k == 3);
                b[8]  = b[8] | (k == 2);
                ins = {1'b0, alt_list[i], 5'b0, 5'(rand_bits(5)), 5'(rand_bits(5)),
                       f3_list[i], rd, exu_pkg::OP};
                execute(ins, p, a, b, model(exu_pkg::OP, f3_list[i], alt_list[i], '0, p, a, b, rd));
            end
        end
        report_test("reg-reg", start);
    endtask

    // ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI, then LUI and AUIPC
    task automatic test_imm();
        logic [2:0]  f3_list [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        int          start;
        word_t       a;
        word_t       b;
        word_t       p;
        word_t       ins;
        word_t       immx;
        logic [11:0] imm12;
        logic [6:0]  opc;
        logic [4:0]  rd;
        start = error_count;
        for (int i = 0; i < 9; i++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                a         = rand_bits(32);
                b         = rand_bits(32);
                p         = rand_bits(30) << 2;
                rd        = 5'(rand_bits(5));
                imm12     = 12'(rand_bits(12));
                imm12[11] = imm12[11] | (k == 0);
                a[31]     = (k == 0);
                // Shifts carry the arithmetic flag in bit 10 above a five bit amount
                if (f3_list[i] == 3'd1 || f3_list[i] == 3'd5)
                    imm12 = {1'b0, (i == 8), 5'b0, imm12[4:0]};
                immx = {{20{imm12[11]}}, imm12};
                ins  = {imm12, 5'(rand_bits(5)), f3_list[i], rd, exu_pkg::OP_IMM};
                execute(ins, p, a, b, model(exu_pkg::OP_IMM, f3_list[i], imm12[10], immx, p, a,
                                            b, rd));
            end
        end
        for (int k = 0; k < 4; k++)
        begin
            opc  = (k < 2) ? exu_pkg::LUI : exu_pkg::AUIPC;
            p    = rand_bits(30) << 2;
            rd   = 5'(rand_bits(5));
            ins  = {20'(rand_bits(20)), rd, opc};
            immx = {ins[31:12], 12'b0};
            execute(ins, p, rand_bits(32), rand_bits(32),
                    model(opc, 3'd0, 1'b0, immx, p, '0, '0, rd));
        end
        report_test("immediate", start);
    endtask

    // BEQ BNE BLT BGE BLTU BGEU on equal, less, greater and mixed-sign pairs
    task automatic test_branch();
        logic [2:0] f3_list [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        int         start;
        word_t      a;
        word_t      b;
        word_t      p;
        word_t      ins;
        word_t      t;
        word_t      immx;
        start = error_count;
        for (int i = 0; i < 6; i++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                a = rand_bits(30);
                b = rand_bits(30);
                p = rand_bits(30) << 2;
                case (k)
                    0:       b = a;
                    1:       b = a + rand_bits(8) + 1;
                    2:       a = b + rand_bits(8) + 1;
                    // Less when signed, greater when unsigned
                    default: a = a | 32'h8000_0000;
                endcase
                t    = rand_bits(12) << 1;
                immx = {{19{t[12]}}, t[12:0]};
                ins  = {immx[12], immx[10:5], 5'(rand_bits(5)), 5'(rand_bits(5)), f3_list[i],
                        immx[4:1], immx[11], exu_pkg::BRANCH};
                execute(ins, p, a, b, model(exu_pkg::BRANCH, f3_list[i], ins[30], immx, p, a, b,
                                            ins[11:7]));
            end
        end
        report_test("branch", start);
    endtask

    task automatic test_jump();
        int         start;
        word_t      a;
        word_t      p;
        word_t      ins;
        word_t      t;
        word_t      immx;
        logic [6:0] opc;
        logic [4:0] rd;
        start = error_count;
        for (int k = 0; k < 6; k++)
        begin
            a    = rand_bits(32);
            p    = rand_bits(30) << 2;
            rd   = 5'(rand_bits(5));
            opc  = (k < 3) ? exu_pkg::JAL : exu_pkg::JALR;
            t    = rand_bits(20) << 1;
            immx = {{11{t[20]}}, t[20:0]};
            ins  = {immx[20], immx[10:1], immx[11], immx[19:12], rd, opc};
            if (k >= 3)
            begin
                // An odd rs1 plus an even offset always needs bit 0 of the target cleared
                a[0] = 1'b1;
                immx = {{20{t[11]}}, t[11:0]};
                ins  = {t[11:0], 5'(rand_bits(5)), 3'b000, rd, opc};
            end
            execute(ins, p, a, rand_bits(32), model(opc, 3'd0, 1'b0, immx, p, a, '0, rd));
        end
        report_test("jump", start);
    endtask

    // Back-to-back stream with a load in slot 4 and bubbles in slots 3 and 6
    task automatic test_stream();
        word_t      ins_q [7];
        word_t      p_q [7];
        word_t      a_q [7];
        word_t      b_q [7];
        rec_t       exp_q [7];
        logic       v_q [7];
        logic [2:0] f3;
        logic       alt;
        logic [4:0] rd;
        int         start;
        int         j;
        start = error_count;
        for (int i = 0; i < 7; i++)
        begin
            a_q[i]   = rand_bits(32);
            b_q[i]   = rand_bits(32);
            p_q[i]   = rand_bits(30) << 2;
            rd       = 5'(rand_bits(5));
            f3       = 3'(rand_bits(3));
            alt      = 1'(rand_bits(1)) & ((f3 == 3'd0) || (f3 == 3'd5));
            v_q[i]   = (i != 3) && (i != 6);
            ins_q[i] = {1'b0, alt, 5'b0, 5'(rand_bits(5)), 5'(rand_bits(5)), f3, rd, exu_pkg::OP};
            exp_q[i] = v_q[i] ? model(exu_pkg::OP, f3, alt, '0, p_q[i], a_q[i], b_q[i], rd) : '0;
        end
        ins_q[4] = {ins_q[4][31:7], 7'b0000011};
        exp_q[4] = model(7'b0000011, 3'd0, 1'b0, '0, p_q[4], a_q[4], b_q[4], ins_q[4][11:7]);
        // Each record is checked in the cycle after its instruction, while the next one enters
        for (int i = 0; i < 8; i++)
        begin
            j = (i < 7) ? i : 6;
            drive(v_q[j], ins_q[j], p_q[j], a_q[j], b_q[j]);
            if (i > 0)
            begin
                @(negedge clk);
                check_record(exp_q[i-1]);
            end
        end
        report_test("stream", start);
    endtask

    initial
    begin
        valid    = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        test_reset();
        test_reg_reg();
        test_imm();
        test_branch();
        test_jump();
        test_stream();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, failed_tests,
                 check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Limit is twice the cycles of reset, reg-reg, immediate, branch, jump and stream tests
    initial
    begin
        int limit;
        limit = 2 * (6 + 10 * 4 * 2 + 22 * 2 + 6 * 4 * 2 + 6 * 2 + 9);
        while (cycle_count < limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verilog.f
logic/exu_pkg.sv
logic/exu_ctrl_if.sv
logic/alu.sv
logic/exu_decoder.sv
logic/exu_writeback.sv
logic/exu_top.sv
dv/exu_clk_gen.sv
dv/exu_tb.sv

//--- Bender.yml
package:
  name: exu

sources:
  # Design, package first
  - logic/exu_pkg.sv
  - logic/exu_ctrl_if.sv
  - logic/alu.sv
  - logic/exu_decoder.sv
  - logic/exu_writeback.sv
  - logic/exu_top.sv
  # Testbench
  - target: test
    files:
      - dv/exu_clk_gen.sv
      - dv/exu_tb.sv
